// ==== icache_params.svh ====
/*
 * Instruction cache geometry and replay queue sizing macros
 */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Direct-mapped geometry over a 16-bit byte address
`define ICACHE_INDEX_BITS  4
`define ICACHE_LINES       (1 << `ICACHE_INDEX_BITS)
`define ICACHE_TAG_BITS    8
`define ICACHE_OFFSET_BITS 4

// Pending fence.i operations
`define REPLAY_DEPTH       4
`define FENCE_ID_BITS      4

`endif

// ==== FlushTypes.sv ====
/*
 * Flush path types
 * Sequencer phase encoding, fence identifier, replay queue entry
 */
`default_nettype none

`include "icache_params.svh"

package FlushTypes;

    // Phases of the flush management unit
    typedef enum logic [1:0] {
        PHASE_FREE         = 2'd0,  // No flush in flight
        PHASE_SEND_REQUEST = 2'd1,  // Waiting for the cache to accept
        PHASE_PROCESSING   = 2'd2,  // Cache walk in progress
        PHASE_WAITING      = 2'd3   // Waiting for the re-issued fence
    } CacheFlushPhase;

    typedef logic [`FENCE_ID_BITS-1:0] FenceId;

    // One slot of the replay queue
    typedef FenceId ReplayEntry;

endpackage

`default_nettype wire

// ==== CacheTypes.sv ====
/*
 * Instruction cache types
 * Address fields, tag entry, address decode helpers
 */
`default_nettype none

`include "icache_params.svh"

package CacheTypes;

    typedef logic [`ICACHE_TAG_BITS+`ICACHE_INDEX_BITS+`ICACHE_OFFSET_BITS-1:0] ICacheAddr;
    typedef logic [`ICACHE_INDEX_BITS-1:0] ICacheIndex;
    typedef logic [`ICACHE_TAG_BITS-1:0]   ICacheTag;

    typedef struct packed {
        logic     valid;
        ICacheTag tag;
    } TagEntry;

    // Line index sits right above the byte offset
    function automatic ICacheIndex getIndex(input ICacheAddr addr);
        return addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    endfunction

    function automatic ICacheTag getTag(input ICacheAddr addr);
        return addr[`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS +: `ICACHE_TAG_BITS];
    endfunction

endpackage

`default_nettype wire

// ==== FlushCtrlIf.sv ====
/*
 * Flush handshake between the flush manager and the instruction cache
 */
`timescale 1ns/1ps
`default_nettype none

interface FlushCtrlIf;

    logic icFlushReq;       // Manager pulse that starts a flush
    logic icFlushReqAck;    // High while the cache can accept a flush
    logic icFlushComplete;  // Cache pulse at the end of the walk
    logic flushComplete;    // High while the manager is waiting

    modport manager (
        output icFlushReq,
        output flushComplete,
        input  icFlushReqAck,
        input  icFlushComplete
    );

    modport cache (
        input  icFlushReq,
        input  flushComplete,
        output icFlushReqAck,
        output icFlushComplete
    );

endinterface

`default_nettype wire

// ==== FenceReplayQueue.sv ====
/*
 * Replay queue for pending fence.i operations
 * Starts a flush per entry, re-issues the fence on completion, retires it
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module FenceReplayQueue (
    input  logic               clock,
    input  logic               reset,
    input  logic               fenceIssue,
    input  FlushTypes::FenceId fenceId,
    output logic               fenceQueueFull,
    output logic               cacheFlushReq,
    input  logic               cacheFlushComplete,
    output logic               flushBusy,
    output logic               fenceRetire,
    output FlushTypes::FenceId retireId
);

    import FlushTypes::*;

    localparam int PtrBits   = $clog2(`REPLAY_DEPTH);
    localparam int CountBits = $clog2(`REPLAY_DEPTH + 1);

    typedef enum logic [1:0] {
        QUEUE_IDLE,
        QUEUE_REQUEST,
        QUEUE_WAIT,
        QUEUE_REISSUE
    } ReplayState;

    ReplayEntry           entries [`REPLAY_DEPTH];
    logic [PtrBits-1:0]   headPtr;
    logic [PtrBits-1:0]   tailPtr;
    logic [CountBits-1:0] entryCount;
    ReplayState           state;
    ReplayState           nextState;
    logic                 push;
    logic                 pop;

    assign fenceQueueFull = (entryCount == CountBits'(`REPLAY_DEPTH));
    assign push           = fenceIssue && !fenceQueueFull;
    assign pop            = (state == QUEUE_REISSUE);

    // Flush request first, then the re-issue pulse together with retire
    assign cacheFlushReq = (state == QUEUE_REQUEST) || (state == QUEUE_REISSUE);
    assign fenceRetire   = (state == QUEUE_REISSUE);
    assign flushBusy     = (state != QUEUE_IDLE);
    assign retireId      = entries[headPtr];

    always_comb begin
        nextState = state;
        case (state)
            QUEUE_IDLE: begin
                if (entryCount != '0) begin
                    nextState = QUEUE_REQUEST;
                end
            end
            QUEUE_REQUEST: nextState = QUEUE_WAIT;
            QUEUE_WAIT: begin
                if (cacheFlushComplete) begin
                    nextState = QUEUE_REISSUE;
                end
            end
            default: nextState = QUEUE_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= QUEUE_IDLE;
            headPtr    <= '0;
            tailPtr    <= '0;
            entryCount <= '0;
        end else begin
            state <= nextState;
            if (push) begin
                tailPtr <= (tailPtr == PtrBits'(`REPLAY_DEPTH - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= (headPtr == PtrBits'(`REPLAY_DEPTH - 1)) ? '0 : headPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                entryCount <= entryCount + 1'b1;
            end else if (pop && !push) begin
                entryCount <= entryCount - 1'b1;
            end
        end
    end

    // Fence id storage
    always_ff @(posedge clock) begin
        if (push) begin
            entries[tailPtr] <= fenceId;
        end
    end

endmodule

`default_nettype wire

// ==== CacheFlushManagementUnit.sv ====
/*
 * Cache flush management unit
 * Four-phase sequencer between the replay queue and the instruction cache
 */
`timescale 1ns/1ps
`default_nettype none

module CacheFlushManagementUnit (
    input  logic       clock,
    input  logic       reset,
    input  logic       cacheFlushReq,
    output logic       cacheFlushComplete,
    FlushCtrlIf.manager flushCtrl
);

    import FlushTypes::*;

    CacheFlushPhase phase;
    CacheFlushPhase nextPhase;

    // Remembers the cache completion pulse while processing
    logic icDoneSeen;
    logic nextIcDoneSeen;

    logic icFlushReq;
    logic waitingLevel;

    always_comb begin
        nextPhase      = phase;
        nextIcDoneSeen = icDoneSeen;
        icFlushReq     = 1'b0;
        waitingLevel   = 1'b0;

        case (phase)
            PHASE_FREE: begin
                if (cacheFlushReq) begin
                    nextPhase = PHASE_SEND_REQUEST;
                end
            end
            PHASE_SEND_REQUEST: begin
                // Hold here until the cache can take the request
                if (flushCtrl.icFlushReqAck) begin
                    icFlushReq     = 1'b1;
                    nextIcDoneSeen = 1'b0;
                    nextPhase      = PHASE_PROCESSING;
                end
            end
            PHASE_PROCESSING: begin
                if (flushCtrl.icFlushComplete) begin
                    nextIcDoneSeen = 1'b1;
                end
                // Move on once the completion pulse has been registered
                if (icDoneSeen) begin
                    nextPhase = PHASE_WAITING;
                end
            end
            PHASE_WAITING: begin
                waitingLevel = 1'b1;
                // Second request is the re-issued fence
                if (cacheFlushReq) begin
                    nextPhase = PHASE_FREE;
                end
            end
            default: begin
                nextPhase = PHASE_FREE;
            end
        endcase
    end

    // Cache side
    assign flushCtrl.icFlushReq    = icFlushReq;
    assign flushCtrl.flushComplete = waitingLevel;

    // Replay queue side
    assign cacheFlushComplete = waitingLevel;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= PHASE_FREE;
        end else begin
            phase <= nextPhase;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            icDoneSeen <= 1'b0;
        end else begin
            icDoneSeen <= nextIcDoneSeen;
        end
    end

endmodule

`default_nettype wire

// ==== ICacheTagArray.sv ====
/*
 * Direct-mapped instruction cache tag array
 * Lookup, line fill, fill blocking during flush
 * Invalidation walk of one line per cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module ICacheTagArray (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  lookupValid,
    input  CacheTypes::ICacheAddr lookupAddr,
    output logic                  lookupDone,
    output logic                  lookupHit,
    input  logic                  fillValid,
    input  CacheTypes::ICacheAddr fillAddr,
    output logic                  fillReady,
    FlushCtrlIf.cache             flushCtrl
);

    import CacheTypes::*;

    localparam ICacheIndex LastIndex = ICacheIndex'(`ICACHE_LINES - 1);

    TagEntry    tagArray [`ICACHE_LINES];
    TagEntry    lookupEntry;
    logic       walking;
    ICacheIndex walkIndex;
    logic       walkDone;
    logic       fillBlocked;
    logic       fillWrite;

    // Fills are refused from the flush request until the manager releases us
    assign fillReady = !(fillBlocked || flushCtrl.icFlushReq);
    assign fillWrite = fillValid && fillReady;

    assign flushCtrl.icFlushReqAck   = !walking;
    assign flushCtrl.icFlushComplete = walkDone;

    assign lookupEntry = tagArray[getIndex(lookupAddr)];

    // Invalidation walk starting the cycle after the request
    always_ff @(posedge clock) begin
        if (reset) begin
            walking   <= 1'b0;
            walkIndex <= '0;
            walkDone  <= 1'b0;
        end else begin
            walkDone <= 1'b0;
            if (flushCtrl.icFlushReq) begin
                walking   <= 1'b1;
                walkIndex <= '0;
            end else if (walking) begin
                walkIndex <= walkIndex + ICacheIndex'(1);
                if (walkIndex == LastIndex) begin
                    walking  <= 1'b0;
                    walkDone <= 1'b1;
                end
            end
        end
    end

    // Set on request and cleared once flushComplete is seen
    always_ff @(posedge clock) begin
        if (reset) begin
            fillBlocked <= 1'b0;
        end else if (flushCtrl.icFlushReq) begin
            fillBlocked <= 1'b1;
        end else if (flushCtrl.flushComplete) begin
            fillBlocked <= 1'b0;
        end
    end

    // Tag storage
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                tagArray[i].valid <= 1'b0;
            end
        end else if (walking) begin
            tagArray[walkIndex].valid <= 1'b0;
        end else if (fillWrite) begin
            tagArray[getIndex(fillAddr)] <= '{valid: 1'b1, tag: getTag(fillAddr)};
        end
    end

    // Lookup result one cycle after the request
    always_ff @(posedge clock) begin
        if (reset) begin
            lookupDone <= 1'b0;
            lookupHit  <= 1'b0;
        end else begin
            lookupDone <= lookupValid;
            lookupHit  <= lookupValid && lookupEntry.valid &&
                          (lookupEntry.tag == getTag(lookupAddr));
        end
    end

endmodule

`default_nettype wire

// ==== ICacheFlushTop.sv ====
/*
 * Instruction cache flush subsystem top level
 * Replay queue, flush manager and tag array
 */
`timescale 1ns/1ps
`default_nettype none

module ICacheFlushTop (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  fenceIssue,
    input  FlushTypes::FenceId    fenceId,
    output logic                  fenceQueueFull,
    output logic                  fenceRetire,
    output FlushTypes::FenceId    retireId,
    output logic                  flushBusy,
    input  logic                  lookupValid,
    input  CacheTypes::ICacheAddr lookupAddr,
    output logic                  lookupDone,
    output logic                  lookupHit,
    input  logic                  fillValid,
    input  CacheTypes::ICacheAddr fillAddr,
    output logic                  fillReady
);

    // Queue to manager
    logic cacheFlushReq;
    logic cacheFlushComplete;

    FlushCtrlIf flushCtrl ();

    FenceReplayQueue replayQueue (
        .clock              (clock),
        .reset              (reset),
        .fenceIssue         (fenceIssue),
        .fenceId            (fenceId),
        .fenceQueueFull     (fenceQueueFull),
        .cacheFlushReq      (cacheFlushReq),
        .cacheFlushComplete (cacheFlushComplete),
        .flushBusy          (flushBusy),
        .fenceRetire        (fenceRetire),
        .retireId           (retireId)
    );

    CacheFlushManagementUnit flushManager (
        .clock              (clock),
        .reset              (reset),
        .cacheFlushReq      (cacheFlushReq),
        .cacheFlushComplete (cacheFlushComplete),
        .flushCtrl          (flushCtrl.manager)
    );

    ICacheTagArray tagArray (
        .clock       (clock),
        .reset       (reset),
        .lookupValid (lookupValid),
        .lookupAddr  (lookupAddr),
        .lookupDone  (lookupDone),
        .lookupHit   (lookupHit),
        .fillValid   (fillValid),
        .fillAddr    (fillAddr),
        .fillReady   (fillReady),
        .flushCtrl   (flushCtrl.cache)
    );

endmodule

`default_nettype wire

// ==== FlushProtocol_sva.sv ====
/*
 * Flush handshake assertions
 * Bound into the flush management unit
 */
`timescale 1ns/1ps
`default_nettype none

module FlushProtocol_sva (
    input logic clock,
    input logic reset,
    input logic cacheFlushReq,
    input logic icFlushReq,
    input logic icFlushReqAck,
    input logic icFlushComplete,
    input logic flushComplete
);

    // Open from a cache flush request until its completion pulse
    logic requestOpen;
    int   assertFailures = 0;

    always_ff @(posedge clock) begin
        if (reset) begin
            requestOpen <= 1'b0;
        end else if (icFlushReq) begin
            requestOpen <= 1'b1;
        end else if (icFlushComplete) begin
            requestOpen <= 1'b0;
        end
    end

    // The cache drops its acknowledge once it has taken the request
    reqNeedsAck: assert property (
        @(posedge clock) disable iff (reset)
        icFlushReq |-> icFlushReqAck ##1 !icFlushReqAck
    ) else begin
        $error("icFlushReq pulsed while icFlushReqAck was low or not taken by the cache");
        assertFailures++;
    end

    completeHeld: assert property (
        @(posedge clock) disable iff (reset)
        flushComplete && !cacheFlushReq |=> flushComplete
    ) else begin
        $error("flushComplete dropped before the next cacheFlushReq");
        assertFailures++;
    end

    completeAfterReq: assert property (
        @(posedge clock) disable iff (reset) icFlushComplete |-> requestOpen
    ) else begin
        $error("icFlushComplete without an earlier icFlushReq");
        assertFailures++;
    end

endmodule

bind CacheFlushManagementUnit FlushProtocol_sva protocolAssertions (
    .clock           (clock),
    .reset           (reset),
    .cacheFlushReq   (cacheFlushReq),
    .icFlushReq      (icFlushReq),
    .icFlushReqAck   (flushCtrl.icFlushReqAck),
    .icFlushComplete (flushCtrl.icFlushComplete),
    .flushComplete   (waitingLevel)
);

`default_nettype wire

// ==== FlushChecker.sv ====
/*
 * Flush path checker
 * Reference tag model, fence order, queue occupancy and lookup comparison
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module FlushChecker (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  fenceIssue,
    input  FlushTypes::FenceId    fenceId,
    input  logic                  fenceQueueFull,
    input  logic                  fenceRetire,
    input  FlushTypes::FenceId    retireId,
    input  logic                  flushBusy,
    input  logic                  lookupValid,
    input  CacheTypes::ICacheAddr lookupAddr,
    input  logic                  lookupDone,
    input  logic                  lookupHit,
    input  logic                  fillValid,
    input  CacheTypes::ICacheAddr fillAddr,
    input  logic                  fillReady,
    input  logic                  traceHit,
    output int                    mismatchCount,
    output int                    failureCount,
    output int                    lookupCount,
    output int                    retireCount,
    output int                    pendingCount
);

    import FlushTypes::*;
    import CacheTypes::*;

    // Tag above index above byte offset
    localparam int IndexLsb = `ICACHE_OFFSET_BITS;
    localparam int TagLsb   = `ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS;

    logic     modelValid [`ICACHE_LINES];
    ICacheTag modelTag   [`ICACHE_LINES];
    FenceId   fenceOrder [$];
    logic     walking       = 1'b0;
    int       walkPos       = 0;
    logic     lastFillReady = 1'b1;
    logic     lookupPending = 1'b0;
    logic     expectHit     = 1'b0;
    logic     resetSeen     = 1'b0;
    int       mismatches    = 0;
    int       failures      = 0;
    int       lookups       = 0;
    int       retires       = 0;
    int       pending       = 0;

    assign mismatchCount = mismatches;
    assign failureCount  = failures;
    assign lookupCount   = lookups;
    assign retireCount   = retires;
    assign pendingCount  = pending;

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0d ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic reportFailure(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        failures++;
    endtask

    always @(posedge clock) begin
        int   line;
        logic modelHit;
        logic modelFull;
        if (reset) begin
            // Outputs settle one edge into reset
            if (resetSeen) begin
                checkValue("fenceRetire", 16'd0, 16'(fenceRetire));
                checkValue("lookupDone", 16'd0, 16'(lookupDone));
                checkValue("flushBusy", 16'd0, 16'(flushBusy));
                checkValue("fenceQueueFull", 16'd0, 16'(fenceQueueFull));
                checkValue("fillReady", 16'd1, 16'(fillReady));
            end
            resetSeen     = 1'b1;
            walking       = 1'b0;
            lookupPending = 1'b0;
            lastFillReady = 1'b1;
            fenceOrder.delete();
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                modelValid[i] = 1'b0;
            end
        end else begin
            // Lookup answer is due one cycle after the request
            checkValue("lookupDone", 16'(lookupPending), 16'(lookupDone));
            if (lookupPending && lookupDone) begin
                checkValue("lookupHit", 16'(expectHit), 16'(lookupHit));
                lookups++;
            end
            lookupPending = lookupValid;
            if (lookupValid) begin
                line      = int'(lookupAddr[IndexLsb +: `ICACHE_INDEX_BITS]);
                modelHit  = modelValid[line] &&
                            (modelTag[line] == lookupAddr[TagLsb +: `ICACHE_TAG_BITS]);
                expectHit = modelHit;
                if (traceHit !== modelHit) begin
                    reportFailure($sformatf("trace hit %0b for address %h, model gives %0b",
                                            traceHit, lookupAddr, modelHit));
                end
            end

            // Fence order and queue occupancy
            modelFull = (fenceOrder.size() == `REPLAY_DEPTH);
            checkValue("fenceQueueFull", 16'(modelFull), 16'(fenceQueueFull));
            if (fenceRetire) begin
                if (fenceOrder.size() == 0) begin
                    reportFailure("fenceRetire pulsed with no fence pending");
                end else begin
                    checkValue("retireId", 16'(fenceOrder[0]), 16'(retireId));
                    void'(fenceOrder.pop_front());
                    retires++;
                end
            end
            if (fenceIssue && !modelFull) begin
                fenceOrder.push_back(fenceId);
            end
            pending = fenceOrder.size();

            if (walking && fillReady) begin
                reportFailure("fillReady high during the invalidation walk");
            end
            if (walking && !flushBusy) begin
                reportFailure("flushBusy low during the invalidation walk");
            end
            if (!flushBusy && !fillReady) begin
                reportFailure("fillReady low with no fence in progress");
            end

            // One line cleared per cycle, starting after the flush request
            if (walking) begin
                modelValid[walkPos] = 1'b0;
                walkPos++;
                if (walkPos == `ICACHE_LINES) begin
                    walking = 1'b0;
                end
            end else if (lastFillReady && !fillReady) begin
                walking = 1'b1;
                walkPos = 0;
            end
            if (fillValid && fillReady) begin
                line             = int'(fillAddr[IndexLsb +: `ICACHE_INDEX_BITS]);
                modelValid[line] = 1'b1;
                modelTag[line]   = fillAddr[TagLsb +: `ICACHE_TAG_BITS];
            end
            lastFillReady = fillReady;
        end
    end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
/*
 * Testbench for the instruction cache flush subsystem
 * Clock, reset, trace driven stimulus, timeout and closing report
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    import FlushTypes::*;
    import CacheTypes::*;

    localparam int TraceDepth  = 64;
    localparam int DriveDelay  = 2;
    localparam int ResetCycles = 10;

    // Operation code in the upper nibble of each trace word
    localparam logic [3:0] OpIdle   = 4'h0;
    localparam logic [3:0] OpFill   = 4'h1;
    localparam logic [3:0] OpLookup = 4'h2;
    localparam logic [3:0] OpFence  = 4'h3;
    localparam logic [3:0] OpQuiet  = 4'h4;
    localparam logic [3:0] OpEnd    = 4'hF;

    logic        clock;
    logic        reset;
    logic        fenceIssue;
    FenceId      fenceId;
    logic        fenceQueueFull;
    logic        fenceRetire;
    FenceId      retireId;
    logic        flushBusy;
    logic        lookupValid;
    ICacheAddr   lookupAddr;
    logic        lookupDone;
    logic        lookupHit;
    logic        fillValid;
    ICacheAddr   fillAddr;
    logic        fillReady;
    logic        traceHit;
    logic [23:0] traceMem [TraceDepth];
    int          traceLength;
    int          timeoutLimit = 0;
    int          cycleCount   = 0;
    int          localErrors  = 0;
    int          mismatchCount;
    int          failureCount;
    int          lookupCount;
    int          retireCount;
    int          pendingCount;

    ICacheFlushTop DUT (
        .clock          (clock),
        .reset          (reset),
        .fenceIssue     (fenceIssue),
        .fenceId        (fenceId),
        .fenceQueueFull (fenceQueueFull),
        .fenceRetire    (fenceRetire),
        .retireId       (retireId),
        .flushBusy      (flushBusy),
        .lookupValid    (lookupValid),
        .lookupAddr     (lookupAddr),
        .lookupDone     (lookupDone),
        .lookupHit      (lookupHit),
        .fillValid      (fillValid),
        .fillAddr       (fillAddr),
        .fillReady      (fillReady)
    );

    FlushChecker monitor (
        .clock          (clock),
        .reset          (reset),
        .fenceIssue     (fenceIssue),
        .fenceId        (fenceId),
        .fenceQueueFull (fenceQueueFull),
        .fenceRetire    (fenceRetire),
        .retireId       (retireId),
        .flushBusy      (flushBusy),
        .lookupValid    (lookupValid),
        .lookupAddr     (lookupAddr),
        .lookupDone     (lookupDone),
        .lookupHit      (lookupHit),
        .fillValid      (fillValid),
        .fillAddr       (fillAddr),
        .fillReady      (fillReady),
        .traceHit       (traceHit),
        .mismatchCount  (mismatchCount),
        .failureCount   (failureCount),
        .lookupCount    (lookupCount),
        .retireCount    (retireCount),
        .pendingCount   (pendingCount)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Inputs change a little after the rising edge
    task automatic nextCycle();
        @(posedge clock);
        #DriveDelay;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) nextCycle();
    endtask

    task automatic applyFill(input ICacheAddr addr);
        while (!fillReady) begin
            nextCycle();
        end
        fillValid = 1'b1;
        fillAddr  = addr;
        nextCycle();
        fillValid = 1'b0;
    endtask

    task automatic applyLookup(input ICacheAddr addr, input logic expected);
        lookupValid = 1'b1;
        lookupAddr  = addr;
        traceHit    = expected;
        nextCycle();
        lookupValid = 1'b0;
        traceHit    = 1'b0;
    endtask

    task automatic applyFence(input FenceId id);
        while (fenceQueueFull) begin
            nextCycle();
        end
        fenceIssue = 1'b1;
        fenceId    = id;
        nextCycle();
        fenceIssue = 1'b0;
    endtask

    // Queue is empty once flushBusy stays low for two cycles in a row
    task automatic waitQuiet();
        int quiet;
        quiet = 0;
        while (quiet < 2) begin
            nextCycle();
            if (flushBusy) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic printSummary();
        $display("Errors: %0d mismatches, %0d other, %0d assertions; %0d lookups, %0d retires",
                 mismatchCount, failureCount + localErrors,
                 DUT.flushManager.protocolAssertions.assertFailures, lookupCount, retireCount);
    endtask

    initial begin
        logic [23:0] word;
        reset       = 1'b1;
        fenceIssue  = 1'b0;
        fenceId     = '0;
        lookupValid = 1'b0;
        lookupAddr  = '0;
        fillValid   = 1'b0;
        fillAddr    = '0;
        traceHit    = 1'b0;
        for (int i = 0; i < TraceDepth; i++) begin
            traceMem[i] = {OpEnd, 20'(i)};
        end
        $readmemh("flush_trace.txt", traceMem);
        traceLength = 0;
        while (traceLength < TraceDepth && traceMem[traceLength][23:20] != OpEnd) begin
            traceLength++;
        end
        timeoutLimit = traceLength * 40 + 500;

        repeat (ResetCycles) @(posedge clock);
        #DriveDelay;
        reset = 1'b0;

        for (int step = 0; step < traceLength; step++) begin
            word = traceMem[step];
            case (word[23:20])
                OpIdle:   idleCycles(int'(word[15:0]));
                OpFill:   applyFill(word[15:0]);
                OpLookup: applyLookup(word[15:0], word[16]);
                OpFence:  applyFence(FenceId'(word[3:0]));
                OpQuiet:  waitQuiet();
                default: begin
                    $display("ERROR: unknown trace operation %h on entry %0d", word[23:20], step);
                    localErrors++;
                end
            endcase
        end
        waitQuiet();
        idleCycles(4);

        if (pendingCount != 0) begin
            $display("ERROR: %0d fences were issued but never retired", pendingCount);
            localErrors++;
        end
        printSummary();
        if (mismatchCount + failureCount + localErrors +
            DUT.flushManager.protocolAssertions.assertFailures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Run limit scales with the trace length
    initial begin
        wait (timeoutLimit > 0);
        while (cycleCount <= timeoutLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("ERROR: timeout, run did not finish within %0d cycles", timeoutLimit);
        printSummary();
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flush_trace.txt ====
// One hex word per line: op[23:20] hit[19:16] value[15:0]
// op 0 idle cycles, 1 fill, 2 lookup, 3 fence id, 4 wait until queue empty, F end
// Nothing valid right after reset
201230
2057f0
200000
// Fill then lookup, same index with another tag misses
101230
1057f0
10a340
211234
2157fc
21a348
209930
20a358
// One fence invalidates every line
300001
400000
201230
2057f0
20a340
// Refill after retire is visible
101230
211230
102220
// Back to back fences, the fifth waits for a free slot
300002
300003
300004
300005
300006
10c1d0
400000
20c1d0
202220
201230
// Fill again once all fences retired
10c1d0
21c1d4
20c2d0
000005
300007
400000
20c1d0
F00000

// ==== all.f ====
+incdir+.
FlushTypes.sv
CacheTypes.sv
FlushCtrlIf.sv
FenceReplayQueue.sv
CacheFlushManagementUnit.sv
ICacheTagArray.sv
ICacheFlushTop.sv
FlushProtocol_sva.sv
FlushChecker.sv
tb_top.sv

// ==== Makefile ====
# Verilator simulation of the instruction cache flush subsystem

LOG = sim.log

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_top -Mdir obj_dir
	./obj_dir/Vtb_top +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Simulation completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean
